//--- logic/lsab_pkg.sv
`default_nettype none

package lsab_pkg;

  // --------------------
  // Buffer geometry
  localparam int LSAB_SECTIONS = 4;
  localparam int SECTION_W = 2;

  // Word counts up to 63 words
  localparam int COUNT_W = 6;

  // --------------------
  // Host register map
  localparam int REG_ADDR_W = 3;
  localparam int REG_DATA_W = 32;

  localparam logic [REG_ADDR_W-1:0] REG_START   = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_COUNT   = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_SECTION = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_CONTROL = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS  = 3'd4;

  // Control write bits
  localparam int CTRL_ISSUE_BIT = 0;
  localparam int CTRL_CLEAR_BIT = 1;

  // --------------------
  // Status read bits
  localparam int STAT_WORKING_BIT  = 0;
  localparam int STAT_IRQ_BIT      = 1;
  localparam int STAT_INT_STOP_BIT = 2;
  localparam int STAT_ABRUPT_BIT   = 3;
  localparam int STAT_SENT_LSB     = 8; // sent count field

endpackage

`default_nettype wire

//--- logic/sync_word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_word_ram #(
  parameter type T_WORD = logic [31:0],
  parameter int  AW     = 4
) (
  input  wire           CLK_n,
  input  wire           i_we,
  input  wire  [AW-1:0] i_waddr,
  input  T_WORD         i_wdata,
  input  wire  [AW-1:0] i_raddr,
  output T_WORD         o_rdata
);

  T_WORD mem [2**AW];

  always_ff @(posedge CLK_n)
  begin
    if (i_we)
    begin
      mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_raddr]; // Registered read gives old data on collision
  end

endmodule

`default_nettype wire

//--- logic/lsab_ingress_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lsab_ingress_buffer import lsab_pkg::*; #(
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 16
) (
  input  wire                     CLK_n,
  input  wire                     RST,
  input  wire                     i_write,
  input  wire  [DATA_W-1:0]       i_data,
  input  wire                     i_int,
  output logic [SECTION_W-1:0]    o_write_slot,
  output logic [LSAB_SECTIONS-1:0] o_section_full,
  output logic [LSAB_SECTIONS-1:0] o_section_empty,
  input  wire                     i_pop,
  input  wire  [SECTION_W-1:0]    i_pop_section,
  output logic [DATA_W-1:0]       o_pop_data,
  output logic                    o_pop_int
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  typedef struct packed {
    logic              int_flag;
    logic [DATA_W-1:0] word;
  } entry_t;

  entry_t wr_entry;
  entry_t rd_entry [LSAB_SECTIONS];
  logic [SECTION_W-1:0] pop_sel; // section of the word now on the read port

  assign wr_entry.int_flag = i_int;
  assign wr_entry.word     = i_data;

  // --------------------
  // Rotating write slot
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_write_slot <= '0;
      pop_sel      <= '0;
    end
    else
    begin
      o_write_slot <= o_write_slot + 1'b1; // wraps every LSAB_SECTIONS clocks
      if (i_pop)
      begin
        pop_sel <= i_pop_section;
      end
    end
  end

  // --------------------
  // One FIFO per section
  for (genvar g = 0; g < LSAB_SECTIONS; g++)
  begin : g_section
    logic             wr_en;
    logic             rd_en;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;

    assign wr_en = i_write && (o_write_slot == SECTION_W'(g)) && !o_section_full[g];
    assign rd_en = i_pop && (i_pop_section == SECTION_W'(g)) && !o_section_empty[g];

    assign o_section_full[g]  = (fill == (PTR_W+1)'(FIFO_DEPTH));
    assign o_section_empty[g] = (fill == '0);

    always_ff @(posedge CLK_n)
    begin
      if (!RST)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill   <= '0;
      end
      else
      begin
        if (wr_en)
          wr_ptr <= wr_ptr + 1'b1;
        if (rd_en)
          rd_ptr <= rd_ptr + 1'b1;
        case ({wr_en, rd_en})
          2'b10:   fill <= fill + 1'b1;
          2'b01:   fill <= fill - 1'b1;
          default: fill <= fill;
        endcase
      end
    end

    sync_word_ram #(
      .T_WORD (entry_t),
      .AW     (PTR_W)
    ) i_ram (
      .CLK_n   (CLK_n),
      .i_we    (wr_en),
      .i_waddr (wr_ptr),
      .i_wdata (wr_entry),
      .i_raddr (rd_ptr),
      .o_rdata (rd_entry[g])
    );
  end

  assign o_pop_data = rd_entry[pop_sel].word;
  assign o_pop_int  = rd_entry[pop_sel].int_flag;

endmodule

`default_nettype wire

//--- logic/block_fill_mover.sv
`timescale 1ns/1ps
`default_nettype none

module block_fill_mover import lsab_pkg::*; #(
  parameter int DATA_W   = 32,
  parameter int STORE_AW = 8
) (
  input  wire                  CLK_n,
  input  wire                  RST,
  input  wire                  i_issue,
  input  wire  [STORE_AW-1:0]  i_start,
  input  wire  [COUNT_W-1:0]   i_count,
  input  wire  [SECTION_W-1:0] i_section,
  input  wire                  i_section_empty,
  output logic                 o_pop,
  output logic [SECTION_W-1:0] o_pop_section,
  input  wire  [DATA_W-1:0]    i_pop_data,
  input  wire                  i_pop_int,
  output logic                 o_store_we,
  output logic [STORE_AW-1:0]  o_store_addr,
  output logic [DATA_W-1:0]    o_store_wdata,
  output logic                 o_working,
  output logic                 o_done,
  output logic [COUNT_W-1:0]   o_count_sent,
  output logic                 o_int_stop,
  output logic                 o_abrupt
);

  logic                 working;
  logic                 valid_q;   // popped word on the read port this cycle
  logic [COUNT_W-1:0]   pops_left;
  logic [COUNT_W-1:0]   sent_q;
  logic [STORE_AW-1:0]  addr_q;
  logic [SECTION_W-1:0] section_q;
  logic                 flag_now;
  logic                 want_more;
  logic                 pop_ok;

  // --------------------
  // Pop decision
  assign flag_now  = valid_q && i_pop_int;
  assign want_more = (pops_left != '0) && !flag_now; // no pops past a flagged word
  assign pop_ok    = working && want_more && !i_section_empty;

  assign o_pop         = pop_ok;
  assign o_pop_section = section_q;

  // Returning word goes straight to the store
  assign o_store_we    = valid_q;
  assign o_store_addr  = addr_q;
  assign o_store_wdata = i_pop_data;

  // Ends on the cycle nothing more is popped; last word in flight lands now
  assign o_done       = working && !pop_ok;
  assign o_count_sent = sent_q + COUNT_W'(valid_q);
  assign o_int_stop   = flag_now;
  assign o_abrupt     = want_more && i_section_empty;
  assign o_working    = working;

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      working   <= 1'b0;
      valid_q   <= 1'b0;
      pops_left <= '0;
      sent_q    <= '0;
      addr_q    <= '0;
      section_q <= '0;
    end
    else if (!working)
    begin
      valid_q <= 1'b0;
      if (i_issue)
      begin
        working   <= 1'b1;
        pops_left <= i_count;
        sent_q    <= '0;
        addr_q    <= i_start;
        section_q <= i_section;
      end
    end
    else
    begin
      valid_q <= pop_ok;
      if (pop_ok)
        pops_left <= pops_left - 1'b1;
      if (valid_q)
      begin
        sent_q <= sent_q + 1'b1;
        addr_q <= addr_q + 1'b1; // wraps at store size
      end
      if (o_done)
        working <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/mover_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mover_regs import lsab_pkg::*; #(
  parameter int STORE_AW = 8
) (
  input  wire                   CLK_n,
  input  wire                   RST,
  input  wire                   i_reg_wr,
  input  wire  [REG_ADDR_W-1:0] i_reg_addr,
  input  wire  [REG_DATA_W-1:0] i_reg_wdata,
  output logic [REG_DATA_W-1:0] o_reg_rdata,
  output logic [STORE_AW-1:0]   o_start,
  output logic [COUNT_W-1:0]    o_count,
  output logic [SECTION_W-1:0]  o_section,
  output logic                  o_issue,
  input  wire                   i_working,
  input  wire                   i_done,
  input  wire  [COUNT_W-1:0]    i_count_sent,
  input  wire                   i_int_stop,
  input  wire                   i_abrupt,
  output logic                  o_irq
);

  logic                  ctrl_wr;
  logic                  clear;
  logic                  int_stop_q;
  logic                  abrupt_q;
  logic [COUNT_W-1:0]    sent_q;
  logic [REG_DATA_W-1:0] status;

  assign ctrl_wr = i_reg_wr && (i_reg_addr == REG_CONTROL);
  assign clear   = ctrl_wr && i_reg_wdata[CTRL_CLEAR_BIT];
  assign o_issue = ctrl_wr && i_reg_wdata[CTRL_ISSUE_BIT] && !i_working; // dropped while busy

  // --------------------
  // Settings and result
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_start    <= '0;
      o_count    <= '0;
      o_section  <= '0;
      o_irq      <= 1'b0;
      int_stop_q <= 1'b0;
      abrupt_q   <= 1'b0;
      sent_q     <= '0;
    end
    else
    begin
      if (i_reg_wr && (i_reg_addr == REG_START))
        o_start <= i_reg_wdata[STORE_AW-1:0];
      if (i_reg_wr && (i_reg_addr == REG_COUNT))
        o_count <= i_reg_wdata[COUNT_W-1:0];
      if (i_reg_wr && (i_reg_addr == REG_SECTION))
        o_section <= i_reg_wdata[SECTION_W-1:0];

      if (clear)
      begin
        o_irq      <= 1'b0;
        int_stop_q <= 1'b0;
        abrupt_q   <= 1'b0;
      end
      // A completion on the same edge wins over clear
      if (i_done)
      begin
        o_irq      <= 1'b1;
        int_stop_q <= i_int_stop;
        abrupt_q   <= i_abrupt;
        sent_q     <= i_count_sent;
      end
    end
  end

  // --------------------
  // Readback
  always_comb
  begin
    status                              = '0;
    status[STAT_WORKING_BIT]            = i_working;
    status[STAT_IRQ_BIT]                = o_irq;
    status[STAT_INT_STOP_BIT]           = int_stop_q;
    status[STAT_ABRUPT_BIT]             = abrupt_q;
    status[STAT_SENT_LSB +: COUNT_W]    = sent_q;
  end

  always_comb
  begin
    case (i_reg_addr)
      REG_START:   o_reg_rdata = REG_DATA_W'(o_start);
      REG_COUNT:   o_reg_rdata = REG_DATA_W'(o_count);
      REG_SECTION: o_reg_rdata = REG_DATA_W'(o_section);
      REG_STATUS:  o_reg_rdata = status;
      default:     o_reg_rdata = '0; // control is write only
    endcase
  end

endmodule

`default_nettype wire

//--- logic/lsab_ingress_core.sv
`timescale 1ns/1ps
`default_nettype none

module lsab_ingress_core import lsab_pkg::*; #(
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 16,
  parameter int STORE_AW   = 8
) (
  input  wire                      CLK_n,
  input  wire                      RST,
  input  wire                      i_write,
  input  wire  [DATA_W-1:0]        i_data,
  input  wire                      i_int,
  output logic [SECTION_W-1:0]     o_write_slot,
  output logic [LSAB_SECTIONS-1:0] o_section_full,
  output logic [LSAB_SECTIONS-1:0] o_section_empty,
  input  wire                      i_reg_wr,
  input  wire  [REG_ADDR_W-1:0]    i_reg_addr,
  input  wire  [REG_DATA_W-1:0]    i_reg_wdata,
  output logic [REG_DATA_W-1:0]    o_reg_rdata,
  output logic                     o_irq,
  input  wire  [STORE_AW-1:0]      i_mem_raddr,
  output logic [DATA_W-1:0]        o_mem_rdata
);

  logic                 pop;
  logic [SECTION_W-1:0] pop_section;
  logic [DATA_W-1:0]    pop_data;
  logic                 pop_int;

  logic [STORE_AW-1:0]  start;
  logic [COUNT_W-1:0]   count;
  logic [SECTION_W-1:0] section;
  logic                 issue;
  logic                 working;
  logic                 done;
  logic                 int_stop;
  logic                 abrupt;
  logic [COUNT_W-1:0]   count_sent;

  logic                 store_we;
  logic [STORE_AW-1:0]  store_addr;
  logic [DATA_W-1:0]    store_wdata;

  lsab_ingress_buffer #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_buffer (
    .CLK_n           (CLK_n),
    .RST             (RST),
    .i_write         (i_write),
    .i_data          (i_data),
    .i_int           (i_int),
    .o_write_slot    (o_write_slot),
    .o_section_full  (o_section_full),
    .o_section_empty (o_section_empty),
    .i_pop           (pop),
    .i_pop_section   (pop_section),
    .o_pop_data      (pop_data),
    .o_pop_int       (pop_int)
  );

  block_fill_mover #(
    .DATA_W   (DATA_W),
    .STORE_AW (STORE_AW)
  ) i_mover (
    .CLK_n           (CLK_n),
    .RST             (RST),
    .i_issue         (issue),
    .i_start         (start),
    .i_count         (count),
    .i_section       (section),
    .i_section_empty (o_section_empty[pop_section]),
    .o_pop           (pop),
    .o_pop_section   (pop_section),
    .i_pop_data      (pop_data),
    .i_pop_int       (pop_int),
    .o_store_we      (store_we),
    .o_store_addr    (store_addr),
    .o_store_wdata   (store_wdata),
    .o_working       (working),
    .o_done          (done),
    .o_count_sent    (count_sent),
    .o_int_stop      (int_stop),
    .o_abrupt        (abrupt)
  );

  mover_regs #(
    .STORE_AW (STORE_AW)
  ) i_regs (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_reg_wr     (i_reg_wr),
    .i_reg_addr   (i_reg_addr),
    .i_reg_wdata  (i_reg_wdata),
    .o_reg_rdata  (o_reg_rdata),
    .o_start      (start),
    .o_count      (count),
    .o_section    (section),
    .o_issue      (issue),
    .i_working    (working),
    .i_done       (done),
    .i_count_sent (count_sent),
    .i_int_stop   (int_stop),
    .i_abrupt     (abrupt),
    .o_irq        (o_irq)
  );

  // Block store with host readback on the read port
  sync_word_ram #(
    .T_WORD (logic [DATA_W-1:0]),
    .AW     (STORE_AW)
  ) i_store (
    .CLK_n   (CLK_n),
    .i_we    (store_we),
    .i_waddr (store_addr),
    .i_wdata (store_wdata),
    .i_raddr (i_mem_raddr),
    .o_rdata (o_mem_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/lsab_ingress_properties.sv
`timescale 1ns/1ps
`default_nettype none

module lsab_ingress_properties import lsab_pkg::*; (
  input wire                     CLK_n,
  input wire                     RST,
  input wire                     i_write,
  input wire [SECTION_W-1:0]     i_write_slot,
  input wire [LSAB_SECTIONS-1:0] i_section_full,
  input wire                     i_working,
  input wire                     i_done,
  input wire                     i_irq
);

  // --------------------
  // Writer side
  a_no_write_when_full: assert property (
    @(posedge CLK_n) disable iff (!RST)
    i_write |-> !i_section_full[i_write_slot]
  ) else $error("write into full section %0d", i_write_slot);

  a_slot_advances: assert property (
    @(posedge CLK_n) disable iff (!RST)
    1'b1 |=> i_write_slot == SECTION_W'($past(i_write_slot) + 1'b1)
  ) else $error("write slot did not advance by one");

  // --------------------
  // Completion
  a_irq_after_done: assert property (
    @(posedge CLK_n) disable iff (!RST)
    $rose(i_irq) |-> $past(i_done) && !i_working // rises only as a transfer ends
  ) else $error("irq rose without a finished transfer");

endmodule

`default_nettype wire

//--- testbench/tb_lsab_ingress_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsab_ingress_core
  import lsab_pkg::*;
();

  localparam int DATA_W       = 32;
  localparam int FIFO_DEPTH   = 16;
  localparam int STORE_AW     = 8;
  localparam int STORE_SIZE   = 2**STORE_AW;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;

  localparam int N_CLEAN      = 10;
  localparam int N_FLAGGED    = 10;
  localparam int FILL_CYCLES  = 24;
  localparam int XFER_WORST   = 160; // program, 63 words, readback, clear
  localparam int N_XFER_MAX   = N_CLEAN + N_FLAGGED + LSAB_SECTIONS * (FIFO_DEPTH + 1) + 2;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 64 + (N_CLEAN + N_FLAGGED) * FILL_CYCLES
                                + 2 * 8 * 16 + N_XFER_MAX * XFER_WORST + 200;

  logic                     CLK_n;
  logic                     RST;
  logic                     i_write;
  logic [DATA_W-1:0]        i_data;
  logic                     i_int;
  logic [SECTION_W-1:0]     o_write_slot;
  logic [LSAB_SECTIONS-1:0] o_section_full;
  logic [LSAB_SECTIONS-1:0] o_section_empty;
  logic                     i_reg_wr;
  logic [REG_ADDR_W-1:0]    i_reg_addr;
  logic [REG_DATA_W-1:0]    i_reg_wdata;
  logic [REG_DATA_W-1:0]    o_reg_rdata;
  logic                     o_irq;
  logic [STORE_AW-1:0]      i_mem_raddr;
  logic [DATA_W-1:0]        o_mem_rdata;

  int seed = 2;
  int cycle_count = 0;
  int since_reset = 0; // Clocks since reset release track the write slot
  int checks = 0;
  int errors = 0;
  int test_checks;
  int test_errors;
  bit last_abrupt;
  bit last_int;

  // Reference model
  logic [DATA_W-1:0] sec_data [LSAB_SECTIONS][FIFO_DEPTH];
  logic              sec_flag [LSAB_SECTIONS][FIFO_DEPTH];
  int                sec_rd   [LSAB_SECTIONS];
  int                sec_wr   [LSAB_SECTIONS];
  int                sec_fill [LSAB_SECTIONS];
  logic [DATA_W-1:0] store_model [STORE_SIZE];
  bit                store_known [STORE_SIZE];

  lsab_ingress_core #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH),
    .STORE_AW   (STORE_AW)
  ) i_dut (
    .CLK_n           (CLK_n),
    .RST             (RST),
    .i_write         (i_write),
    .i_data          (i_data),
    .i_int           (i_int),
    .o_write_slot    (o_write_slot),
    .o_section_full  (o_section_full),
    .o_section_empty (o_section_empty),
    .i_reg_wr        (i_reg_wr),
    .i_reg_addr      (i_reg_addr),
    .i_reg_wdata     (i_reg_wdata),
    .o_reg_rdata     (o_reg_rdata),
    .o_irq           (o_irq),
    .i_mem_raddr     (i_mem_raddr),
    .o_mem_rdata     (o_mem_rdata)
  );

  bind lsab_ingress_core lsab_ingress_properties i_props (
    .CLK_n          (CLK_n),
    .RST            (RST),
    .i_write        (i_write),
    .i_write_slot   (o_write_slot),
    .i_section_full (o_section_full),
    .i_working      (working),
    .i_done         (done),
    .i_irq          (o_irq)
  );

  // --------------------
  // Clock and run limit
  initial
  begin
    CLK_n = 1'b0;
    forever
    begin
      #(CLK_PERIOD/2) CLK_n = ~CLK_n;
    end
  end

  always @(posedge CLK_n)
  begin
    cycle_count <= cycle_count + 1;
    if (!RST)
      since_reset <= 0;
    else
      since_reset <= since_reset + 1;
  end

  always @(posedge CLK_n)
  begin
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // --------------------
  // Helpers start and end on a falling edge
  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic int buffered_words();
    int total;
    total = 0;
    for (int s = 0; s < LSAB_SECTIONS; s++)
      total += sec_fill[s];
    return total;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_errors)
      $display("test %0d %s: ok, %0d checks", num, name, checks - test_checks);
    else
      $display("test %0d %s: %0d errors in %0d checks", num, name,
               errors - test_errors, checks - test_checks);
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    i_reg_wr    = 1'b1;
    i_reg_addr  = addr;
    i_reg_wdata = data;
    @(negedge CLK_n);
    i_reg_wr    = 1'b0;
    i_reg_wdata = '0;
  endtask

  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
    i_reg_addr = addr;
    #(CLK_PERIOD/4); // combinational readback settles
    data = o_reg_rdata;
    @(negedge CLK_n);
  endtask

  task automatic mem_read(input int addr, output logic [DATA_W-1:0] data);
    i_mem_raddr = STORE_AW'(addr);
    @(negedge CLK_n);
    data = o_mem_rdata;
  endtask

  task automatic check_levels();
    logic [LSAB_SECTIONS-1:0] exp_full;
    logic [LSAB_SECTIONS-1:0] exp_empty;
    for (int s = 0; s < LSAB_SECTIONS; s++)
    begin
      exp_full[s]  = (sec_fill[s] == FIFO_DEPTH);
      exp_empty[s] = (sec_fill[s] == 0);
    end
    compare_value("full levels", 32'(o_section_full), 32'(exp_full));
    compare_value("empty levels", 32'(o_section_empty), 32'(exp_empty));
  endtask

  // Random writes into the current slot without overfilling
  task automatic fill_sections(input int cycles, input int flag_odds);
    int s;
    logic [DATA_W-1:0] word;
    logic flag;
    for (int c = 0; c < cycles; c++)
    begin
      check_levels();
      s = since_reset % LSAB_SECTIONS;
      compare_value("write slot", 32'(o_write_slot), 32'(s));
      i_write = 1'b0;
      if (sec_fill[s] < FIFO_DEPTH && rand_below(4) != 0)
      begin
        word = $random(seed);
        flag = (flag_odds != 0) && (rand_below(flag_odds) == 0);
        i_write = 1'b1;
        i_data  = word;
        i_int   = flag;
        sec_data[s][sec_wr[s]] = word;
        sec_flag[s][sec_wr[s]] = flag;
        sec_wr[s]   = (sec_wr[s] + 1) % FIFO_DEPTH;
        sec_fill[s] = sec_fill[s] + 1;
      end
      @(negedge CLK_n);
    end
    i_write = 1'b0;
    i_int   = 1'b0;
  endtask

  task automatic run_transfer(input int s, input int start, input int count,
                              input bit reissue);
    int exp_sent;
    bit exp_int;
    bit exp_abrupt;
    int addr;
    logic [31:0] rd;
    logic [DATA_W-1:0] word;
    logic [31:0] exp_status;
    exp_sent   = 0;
    exp_int    = 1'b0;
    exp_abrupt = 1'b0;
    // Walk the section queue the way the transfer should
    while (exp_sent < count && !exp_int && !exp_abrupt)
    begin
      if (sec_fill[s] == 0)
        exp_abrupt = 1'b1;
      else
      begin
        addr = (start + exp_sent) % STORE_SIZE;
        store_model[addr] = sec_data[s][sec_rd[s]];
        store_known[addr] = 1'b1;
        exp_int     = sec_flag[s][sec_rd[s]];
        sec_rd[s]   = (sec_rd[s] + 1) % FIFO_DEPTH;
        sec_fill[s] = sec_fill[s] - 1;
        exp_sent++;
      end
    end

    reg_write(REG_START, 32'(start));
    reg_write(REG_COUNT, 32'(count));
    reg_write(REG_SECTION, 32'(s));
    reg_read(REG_START, rd);
    compare_value("start readback", rd, 32'(start));
    reg_read(REG_COUNT, rd);
    compare_value("count readback", rd, 32'(count));
    reg_read(REG_SECTION, rd);
    compare_value("section readback", rd, 32'(s));
    reg_write(REG_CONTROL, 32'(1) << CTRL_ISSUE_BIT);
    if (reissue)
    begin
      reg_read(REG_STATUS, rd);
      compare_value("working during transfer", 32'(rd[STAT_WORKING_BIT]), 32'd1);
      reg_write(REG_START, 32'd0);
      reg_write(REG_CONTROL, 32'(1) << CTRL_ISSUE_BIT); // must be dropped
    end

    while (!o_irq)
      @(negedge CLK_n);

    exp_status = (32'(exp_sent) << STAT_SENT_LSB)
               | (32'(exp_abrupt) << STAT_ABRUPT_BIT)
               | (32'(exp_int) << STAT_INT_STOP_BIT)
               | (32'd1 << STAT_IRQ_BIT);
    reg_read(REG_STATUS, rd);
    compare_value("status after done", rd, exp_status);

    for (int k = 0; k <= exp_sent; k++)
    begin
      addr = (start + k) % STORE_SIZE;
      mem_read(addr, word);
      if (store_known[addr])
        compare_value($sformatf("store word %0d", addr), word, store_model[addr]);
    end

    compare_value("irq before clear", 32'(o_irq), 32'd1);
    reg_write(REG_CONTROL, 32'(1) << CTRL_CLEAR_BIT);
    compare_value("irq after clear", 32'(o_irq), 32'd0);
    reg_read(REG_STATUS, rd);
    compare_value("status after clear", rd, 32'(exp_sent) << STAT_SENT_LSB);
    if (reissue)
    begin
      repeat (4) @(negedge CLK_n);
      reg_read(REG_STATUS, rd);
      compare_value("status after ignored issue", rd, 32'(exp_sent) << STAT_SENT_LSB);
      compare_value("irq after ignored issue", 32'(o_irq), 32'd0);
    end
    check_levels();
    last_abrupt = exp_abrupt;
    last_int    = exp_int;
  endtask

  // --------------------
  // Test sequence
  initial
  begin
    logic [31:0] rd;
    int s;
    int n;
    int count;
    int guard;
    int int_stops;
    RST         = 1'b0;
    i_write     = 1'b0;
    i_data      = '0;
    i_int       = 1'b0;
    i_reg_wr    = 1'b0;
    i_reg_addr  = '0;
    i_reg_wdata = '0;
    i_mem_raddr = '0;
    repeat (RESET_CYCLES) @(negedge CLK_n);
    RST = 1'b1;

    begin_test();
    for (int i = 0; i < 8; i++)
    begin
      compare_value("write slot after reset", 32'(o_write_slot), 32'(i % LSAB_SECTIONS));
      @(negedge CLK_n);
    end
    check_levels();
    reg_read(REG_STATUS, rd);
    compare_value("status after reset", rd, 32'd0);
    reg_read(REG_START, rd);
    compare_value("start after reset", rd, 32'd0);
    reg_read(REG_COUNT, rd);
    compare_value("count after reset", rd, 32'd0);
    reg_read(REG_SECTION, rd);
    compare_value("section after reset", rd, 32'd0);
    end_test(1, "reset state");

    begin_test();
    fill_sections(64, 0);
    guard = 0;
    while (buffered_words() < LSAB_SECTIONS * FIFO_DEPTH && guard < 8)
    begin
      fill_sections(16, 0);
      guard++;
    end
    check_levels();
    if (buffered_words() < LSAB_SECTIONS * FIFO_DEPTH)
    begin
      errors++;
      $display("Sections did not fill up during the write phase");
    end
    end_test(2, "section fill levels");

    begin_test();
    for (n = 0; n < N_CLEAN; n++)
    begin
      fill_sections(FILL_CYCLES, 0);
      s = rand_below(LSAB_SECTIONS);
      count = (sec_fill[s] == 0) ? 0 : 1 + rand_below(sec_fill[s]);
      run_transfer(s, rand_below(STORE_SIZE), count, 1'b0);
    end
    end_test(3, "clean transfers");

    begin_test();
    int_stops = 0;
    for (n = 0; n < N_FLAGGED; n++)
    begin
      fill_sections(FILL_CYCLES, 3);
      s = rand_below(LSAB_SECTIONS);
      count = (sec_fill[s] == 0) ? 0 : 1 + rand_below(sec_fill[s]);
      run_transfer(s, rand_below(STORE_SIZE), count, 1'b0);
      int_stops = int_stops + 32'(last_int);
    end
    if (int_stops == 0)
    begin
      errors++;
      $display("No transfer ended on a flagged word");
    end
    end_test(4, $sformatf("interrupt stop, %0d stops", int_stops));

    // Drain every section until it runs dry mid transfer
    begin_test();
    for (s = 0; s < LSAB_SECTIONS; s++)
    begin
      guard = 0;
      last_abrupt = 1'b0;
      while (!last_abrupt && guard <= FIFO_DEPTH)
      begin
        count = sec_fill[s] + 1 + rand_below(8);
        run_transfer(s, rand_below(STORE_SIZE), count, 1'b0);
        guard++;
      end
      if (!last_abrupt)
      begin
        errors++;
        $display("Section %0d never reached an abrupt stop", s);
      end
    end
    run_transfer(rand_below(LSAB_SECTIONS), rand_below(STORE_SIZE), 0, 1'b0);
    end_test(5, "abrupt stop and zero count");

    begin_test();
    s = rand_below(LSAB_SECTIONS);
    guard = 0;
    while (sec_fill[s] < 8 && guard < 8)
    begin
      fill_sections(16, 0);
      guard++;
    end
    run_transfer(s, STORE_SIZE - 4, sec_fill[s], 1'b1); // crosses the top of the store
    end_test(6, "ignored issue and address wrap");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
logic/lsab_pkg.sv
logic/sync_word_ram.sv
logic/lsab_ingress_buffer.sv
logic/block_fill_mover.sv
logic/mover_regs.sv
logic/lsab_ingress_core.sv
testbench/lsab_ingress_properties.sv
testbench/tb_lsab_ingress_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsab_ingress_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
